//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_pipelined_cpu
FILELIST  ?= cpu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cpu_core.f
design/rv_isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/pl_alu.sv
design/pl_decoder.sv
design/pl_register_file.sv
design/pl_hazard_unit.sv
design/pl_stage_reg.sv
design/pl_execute.sv
design/pipelined_cpu.sv
sim/tb_clock.sv
sim/tb_pipelined_cpu.sv

//--- design/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;
  import rv_isa_pkg::*;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [1:0] {fwd_none, fwd_mem, fwd_wb} fwd_sel_e;

  // res_imm carries the lui value
  typedef enum logic [1:0] {res_alu, res_mem, res_pc4, res_imm} result_src_e;

  typedef enum logic [1:0] {br_none, br_cond, br_jal, br_jalr} branch_kind_e;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t pc4;
  } de_payload_t;

  typedef struct packed {
    alu_op_e      alu_op;
    logic         use_imm;
    logic         reg_write;
    logic         mem_write;
    logic         is_load;
    result_src_e  result_src;
    branch_kind_e branch_kind;
    word_t        rd1;
    word_t        rd2;
    word_t        imm;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        pc;
    word_t        pc4;
    logic [2:0]   funct3;
  } ex_payload_t;

  typedef struct packed {
    logic        reg_write;
    logic        mem_write;
    result_src_e result_src;
    reg_idx_t    rd;
    word_t       alu_result;
    word_t       store_data;
    word_t       imm;
    word_t       pc4;
  } mem_payload_t;

  typedef struct packed {
    logic     reg_write;
    reg_idx_t rd;
    word_t    result;
  } wb_payload_t;

  // Bubble contents per stage
  localparam de_payload_t de_bubble = '{instr: nop_instr, pc: '0, pc4: '0};

  localparam ex_payload_t ex_bubble = '{
    alu_op: alu_add, use_imm: 1'b0, reg_write: 1'b0, mem_write: 1'b0,
    is_load: 1'b0, result_src: res_alu, branch_kind: br_none,
    rd1: '0, rd2: '0, imm: '0, rs1: '0, rs2: '0, rd: '0,
    pc: '0, pc4: '0, funct3: '0
  };

  localparam mem_payload_t mem_bubble = '{
    reg_write: 1'b0, mem_write: 1'b0, result_src: res_alu, rd: '0,
    alu_result: '0, store_data: '0, imm: '0, pc4: '0
  };

  localparam wb_payload_t wb_bubble = '{reg_write: 1'b0, rd: '0, result: '0};

endpackage

//--- design/pipelined_cpu.sv
`timescale 1ns/1ps

module pipelined_cpu import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  output word_t instr_addr,
  input  word_t instr_data,
  output word_t data_addr,
  output word_t data_wdata,
  output logic  data_we,
  input  word_t data_rdata
);

  word_t        pc_f;
  word_t        pc_plus4_f;
  de_payload_t  de_d, de_q;
  ex_payload_t  ex_d, ex_q;
  mem_payload_t mem_d, mem_q;
  wb_payload_t  wb_d, wb_q;

  reg_idx_t     rs1_d, rs2_d, rd_d;
  alu_op_e      alu_op_d;
  logic         use_imm_d, reg_write_d, mem_write_d, is_load_d;
  result_src_e  result_src_d;
  branch_kind_e branch_kind_d;
  word_t        imm_d, rd1_d, rd2_d;

  fwd_sel_e     fwd_a, fwd_b;
  logic         stall_f, stall_d, flush_d, flush_e;
  word_t        alu_result_e, store_data_e, branch_target_e;
  logic         branch_taken_e;
  word_t        mem_fwd, result_m;

  // Fetch
  assign pc_plus4_f = pc_f + 32'd4;
  assign instr_addr = pc_f;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_f <= '0;
    end else if (!stall_f) begin
      pc_f <= branch_taken_e ? branch_target_e : pc_plus4_f;
    end
  end

  assign de_d = '{instr: instr_data, pc: pc_f, pc4: pc_plus4_f};

  pl_stage_reg #(.payload_t(de_payload_t), .bubble(de_bubble)) u_de_reg (
    .clk(clk), .rst_n(rst_n), .hold(stall_d), .flush(flush_d), .d(de_d), .q(de_q)
  );

  // Decode
  assign rs1_d = de_q.instr[rs1_lsb +: reg_addr_w];
  assign rs2_d = de_q.instr[rs2_lsb +: reg_addr_w];
  assign rd_d  = de_q.instr[rd_lsb +: reg_addr_w];

  pl_decoder u_decoder (
    .instr       (de_q.instr),
    .alu_op      (alu_op_d),
    .use_imm     (use_imm_d),
    .reg_write   (reg_write_d),
    .mem_write   (mem_write_d),
    .is_load     (is_load_d),
    .result_src  (result_src_d),
    .branch_kind (branch_kind_d),
    .imm         (imm_d)
  );

  pl_register_file u_regfile (
    .clk   (clk),
    .rst_n (rst_n),
    .ra1   (rs1_d),
    .ra2   (rs2_d),
    .rd1   (rd1_d),
    .rd2   (rd2_d),
    .wa    (wb_q.rd),
    .we    (wb_q.reg_write),
    .wd    (wb_q.result)
  );

  assign ex_d = '{
    alu_op: alu_op_d, use_imm: use_imm_d, reg_write: reg_write_d,
    mem_write: mem_write_d, is_load: is_load_d, result_src: result_src_d,
    branch_kind: branch_kind_d, rd1: rd1_d, rd2: rd2_d, imm: imm_d,
    rs1: rs1_d, rs2: rs2_d, rd: rd_d, pc: de_q.pc, pc4: de_q.pc4,
    funct3: de_q.instr[f3_lsb +: 3]
  };

  pl_stage_reg #(.payload_t(ex_payload_t), .bubble(ex_bubble)) u_ex_reg (
    .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(flush_e), .d(ex_d), .q(ex_q)
  );

  pl_hazard_unit u_hazard (
    .rs1_d        (rs1_d),
    .rs2_d        (rs2_d),
    .rs1_e        (ex_q.rs1),
    .rs2_e        (ex_q.rs2),
    .rd_e         (ex_q.rd),
    .rd_m         (mem_q.rd),
    .rd_w         (wb_q.rd),
    .is_load_e    (ex_q.is_load),
    .reg_write_m  (mem_q.reg_write),
    .reg_write_w  (wb_q.reg_write),
    .branch_taken (branch_taken_e),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .stall_f      (stall_f),
    .stall_d      (stall_d),
    .flush_d      (flush_d),
    .flush_e      (flush_e)
  );

  // Execute
  pl_execute u_execute (
    .ex            (ex_q),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .mem_fwd       (mem_fwd),
    .wb_fwd        (wb_q.result),
    .alu_result    (alu_result_e),
    .store_data    (store_data_e),
    .branch_taken  (branch_taken_e),
    .branch_target (branch_target_e)
  );

  assign mem_d = '{
    reg_write: ex_q.reg_write, mem_write: ex_q.mem_write, result_src: ex_q.result_src,
    rd: ex_q.rd, alu_result: alu_result_e, store_data: store_data_e,
    imm: ex_q.imm, pc4: ex_q.pc4
  };

  pl_stage_reg #(.payload_t(mem_payload_t), .bubble(mem_bubble)) u_mem_reg (
    .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(1'b0), .d(mem_d), .q(mem_q)
  );

  // Memory
  assign data_addr  = mem_q.alu_result;
  assign data_wdata = mem_q.store_data;
  assign data_we    = mem_q.mem_write;

  // Load data is never forwarded from here, the stall covers it
  always_comb begin
    case (mem_q.result_src)
      res_pc4: mem_fwd = mem_q.pc4;
      res_imm: mem_fwd = mem_q.imm;
      default: mem_fwd = mem_q.alu_result;
    endcase
  end

  assign result_m = (mem_q.result_src == res_mem) ? data_rdata : mem_fwd;

  assign wb_d = '{reg_write: mem_q.reg_write, rd: mem_q.rd, result: result_m};

  pl_stage_reg #(.payload_t(wb_payload_t), .bubble(wb_bubble)) u_wb_reg (
    .clk(clk), .rst_n(rst_n), .hold(1'b0), .flush(1'b0), .d(wb_d), .q(wb_q)
  );

endmodule

//--- design/pl_alu.sv
`timescale 1ns/1ps

module pl_alu import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result,
  output logic    zero,
  output logic    lt,
  output logic    ltu
);

  logic [4:0] shamt;

  assign shamt = b[4:0];
  assign lt    = $signed(a) < $signed(b);
  assign ltu   = a < b;

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_slt:  result = {31'b0, lt};
      alu_sltu: result = {31'b0, ltu};
      alu_sll:  result = a << shamt;
      alu_srl:  result = a >> shamt;
      alu_sra:  result = word_t'($signed(a) >>> shamt);
      default:  result = a + b;
    endcase
  end

  // beq/bne look at this after a subtract
  assign zero = (result == '0);

endmodule

//--- design/pl_decoder.sv
`timescale 1ns/1ps

module pl_decoder import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  word_t        instr,
  output alu_op_e      alu_op,
  output logic         use_imm,
  output logic         reg_write,
  output logic         mem_write,
  output logic         is_load,
  output result_src_e  result_src,
  output branch_kind_e branch_kind,
  output word_t        imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = instr[6:0];
  assign funct3 = instr[f3_lsb +: 3];
  assign alt    = instr[f7_alt_bit];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic alu_op_e op_from_funct3(input logic [2:0] f3, input logic sub_sra);
    alu_op_e op;
    case (f3)
      f3_add_sub: op = sub_sra ? alu_sub : alu_add;
      f3_sll:     op = alu_sll;
      f3_slt:     op = alu_slt;
      f3_sltu:    op = alu_sltu;
      f3_xor:     op = alu_xor;
      f3_srl_sra: op = sub_sra ? alu_sra : alu_srl;
      f3_or:      op = alu_or;
      f3_and:     op = alu_and;
      default:    op = alu_add;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_op      = alu_add;
    use_imm     = 1'b0;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    is_load     = 1'b0;
    result_src  = res_alu;
    branch_kind = br_none;
    imm         = '0;

    case (opcode)
      op_rtype: begin
        alu_op    = op_from_funct3(funct3, alt);
        reg_write = 1'b1;
      end
      op_itype: begin
        // Bit 30 only selects a shift type for immediates
        alu_op    = op_from_funct3(funct3, alt && funct3 == f3_srl_sra);
        use_imm   = 1'b1;
        reg_write = 1'b1;
        imm       = imm_i;
      end
      op_lui: begin
        reg_write  = 1'b1;
        result_src = res_imm;
        imm        = imm_u;
      end
      op_load: begin
        use_imm    = 1'b1;
        reg_write  = 1'b1;
        is_load    = 1'b1;
        result_src = res_mem;
        imm        = imm_i;
      end
      op_store: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
        imm       = imm_s;
      end
      op_branch: begin
        alu_op      = alu_sub;
        branch_kind = br_cond;
        imm         = imm_b;
      end
      op_jal: begin
        reg_write   = 1'b1;
        result_src  = res_pc4;
        branch_kind = br_jal;
        imm         = imm_j;
      end
      op_jalr: begin
        use_imm     = 1'b1;
        reg_write   = 1'b1;
        result_src  = res_pc4;
        branch_kind = br_jalr;
        imm         = imm_i;
      end
      default: begin
      end
    endcase
  end

endmodule

//--- design/pl_execute.sv
`timescale 1ns/1ps

module pl_execute import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  ex_payload_t ex,
  input  fwd_sel_e    fwd_a,
  input  fwd_sel_e    fwd_b,
  input  word_t       mem_fwd,
  input  word_t       wb_fwd,
  output word_t       alu_result,
  output word_t       store_data,
  output logic        branch_taken,
  output word_t       branch_target
);

  word_t op_a;
  word_t op_b_reg;
  word_t op_b;
  logic  zero;
  logic  lt;
  logic  ltu;
  logic  cond_met;

  always_comb begin
    case (fwd_a)
      fwd_none: op_a = ex.rd1;
      fwd_mem:  op_a = mem_fwd;
      fwd_wb:   op_a = wb_fwd;
      default:  op_a = ex.rd1;
    endcase

    case (fwd_b)
      fwd_none: op_b_reg = ex.rd2;
      fwd_mem:  op_b_reg = mem_fwd;
      fwd_wb:   op_b_reg = wb_fwd;
      default:  op_b_reg = ex.rd2;
    endcase
  end

  assign op_b       = ex.use_imm ? ex.imm : op_b_reg;
  assign store_data = op_b_reg;

  pl_alu u_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (ex.alu_op),
    .result (alu_result),
    .zero   (zero),
    .lt     (lt),
    .ltu    (ltu)
  );

  always_comb begin
    case (ex.funct3)
      f3_beq:  cond_met = zero;
      f3_bne:  cond_met = !zero;
      f3_blt:  cond_met = lt;
      f3_bge:  cond_met = !lt;
      f3_bltu: cond_met = ltu;
      f3_bgeu: cond_met = !ltu;
      default: cond_met = 1'b0;
    endcase
  end

  assign branch_taken = (ex.branch_kind == br_cond && cond_met) ||
                        ex.branch_kind == br_jal || ex.branch_kind == br_jalr;

  // jalr adds rs1 + imm in the ALU
  assign branch_target = (ex.branch_kind == br_jalr) ? {alu_result[31:1], 1'b0}
                                                     : ex.pc + ex.imm;

endmodule

//--- design/pl_hazard_unit.sv
`timescale 1ns/1ps

module pl_hazard_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
  input  reg_idx_t rs1_d,
  input  reg_idx_t rs2_d,
  input  reg_idx_t rs1_e,
  input  reg_idx_t rs2_e,
  input  reg_idx_t rd_e,
  input  reg_idx_t rd_m,
  input  reg_idx_t rd_w,
  input  logic     is_load_e,
  input  logic     reg_write_m,
  input  logic     reg_write_w,
  input  logic     branch_taken,
  output fwd_sel_e fwd_a,
  output fwd_sel_e fwd_b,
  output logic     stall_f,
  output logic     stall_d,
  output logic     flush_d,
  output logic     flush_e
);

  logic load_use;

  always_comb begin
    fwd_a = fwd_none;
    if (rs1_e != '0 && rs1_e == rd_m && reg_write_m) begin
      fwd_a = fwd_mem;
    end else if (rs1_e != '0 && rs1_e == rd_w && reg_write_w) begin
      fwd_a = fwd_wb;
    end

    fwd_b = fwd_none;
    if (rs2_e != '0 && rs2_e == rd_m && reg_write_m) begin
      fwd_b = fwd_mem;
    end else if (rs2_e != '0 && rs2_e == rd_w && reg_write_w) begin
      fwd_b = fwd_wb;
    end
  end

  assign load_use = is_load_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

  // Redirect wins over the load-use hold
  assign stall_f = load_use && !branch_taken;
  assign stall_d = load_use && !branch_taken;
  assign flush_d = branch_taken;
  assign flush_e = branch_taken || load_use;

endmodule

//--- design/pl_register_file.sv
`timescale 1ns/1ps

module pl_register_file import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t ra1,
  input  reg_idx_t ra2,
  output word_t    rd1,
  output word_t    rd2,
  input  reg_idx_t wa,
  input  logic     we,
  input  word_t    wd
);

  word_t regs [32];
  logic  wr_en;

  // x0 is never written, so it stays at its reset value
  assign wr_en = we && (wa != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wa] <= wd;
    end
  end

  // Same-cycle write bypass
  assign rd1 = (wr_en && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (wr_en && wa == ra2) ? wd : regs[ra2];

endmodule

//--- design/pl_stage_reg.sv
`timescale 1ns/1ps

module pl_stage_reg #(
  parameter type      payload_t = logic,
  parameter payload_t bubble    = '0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= bubble;
    end else if (flush) begin
      q <= bubble;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // Major opcodes, bits 6:0
  localparam logic [6:0] op_rtype  = 7'b0110011;
  localparam logic [6:0] op_itype  = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // ALU funct3
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // Field positions
  localparam int rd_lsb     = 7;
  localparam int f3_lsb     = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int f7_alt_bit = 30;

  // addi x0, x0, 0
  localparam word_t nop_instr = 32'h0000_0013;

endpackage

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
  end

  always #5 clk = ~clk;

  task automatic hold_reset();
    @(posedge clk);
    rst_n <= 1'b0;
  endtask

  // Reset stays low for 4 cycles
  task automatic release_reset();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
  endtask

endmodule

//--- sim/tb_pipelined_cpu.sv
`timescale 1ns/1ps

module tb_pipelined_cpu import rv_isa_pkg::*; ();

  typedef enum int {
    k_add, k_sub, k_and, k_or, k_xor, k_slt, k_sltu, k_sll, k_srl, k_sra
  } op_kind_e;

  localparam word_t halt_addr = 32'h0000_03fc;

  logic  clk;
  logic  rst_n;
  word_t instr_addr;
  word_t instr_data;
  word_t data_addr;
  word_t data_wdata;
  logic  data_we;
  word_t data_rdata;

  word_t imem [256];
  word_t dmem [256];
  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t got_addr [$];
  word_t got_data [$];
  word_t mdl [32];

  word_t lcg_state;
  int    store_ptr;
  logic  halted;
  logic  running;
  int    cycle_count;
  int    cycle_limit;
  string test_name;
  int    error_count;
  int    test_count;
  int    failed_tests;

  tb_clock u_clk (.clk(clk), .rst_n(rst_n));

  pipelined_cpu DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_addr (instr_addr),
    .instr_data (instr_data),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_rdata (data_rdata)
  );

  assign instr_data = imem[instr_addr[9:2]];
  assign data_rdata = dmem[data_addr[9:2]];

  // Record stores until the halt store
  always @(posedge clk) begin
    if (rst_n && data_we) begin
      if (data_addr == halt_addr) begin
        halted <= 1'b1;
      end else begin
        got_addr.push_back(data_addr);
        got_data.push_back(data_wdata);
        dmem[data_addr[9:2]] <= data_wdata;
      end
    end
  end

  always @(posedge clk) begin
    if (running) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("Timeout: %s did not reach its halt store within %0d cycles",
                 test_name, cycle_limit);
        error_count++;
        finish_run();
      end
    end
  end

  function word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t fill_word(int idx);
    return 32'hda7a_0000 + word_t'(idx) * 32'd4;
  endfunction

  function automatic word_t enc_r(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), op_rtype};
  endfunction

  function automatic word_t enc_i(logic [6:0] op, int f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic word_t enc_s(int rs2, int rs1, int imm);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], op_store};
  endfunction

  function automatic word_t enc_b(int f3, int rs1, int rs2, int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], op_branch};
  endfunction

  function automatic word_t enc_j(int rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), op_jal};
  endfunction

  function automatic int kind_f3(op_kind_e k);
    case (k)
      k_sll:        return 1;
      k_slt:        return 2;
      k_sltu:       return 3;
      k_xor:        return 4;
      k_srl, k_sra: return 5;
      k_or:         return 6;
      k_and:        return 7;
      default:      return 0;
    endcase
  endfunction

  // RV32I result of one ALU operation
  function automatic word_t ref_op(op_kind_e k, word_t a, word_t b);
    case (k)
      k_add:   return a + b;
      k_sub:   return a - b;
      k_and:   return a & b;
      k_or:    return a | b;
      k_xor:   return a ^ b;
      k_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      k_sltu:  return (a < b) ? 32'd1 : 32'd0;
      k_sll:   return a << b[4:0];
      k_srl:   return a >> b[4:0];
      default: return word_t'($signed(a) >>> b[4:0]);
    endcase
  endfunction

  function automatic logic ref_cond(int f3, word_t a, word_t b);
    case (f3)
      0:       return a == b;
      1:       return a != b;
      4:       return $signed(a) < $signed(b);
      5:       return $signed(a) >= $signed(b);
      6:       return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic void set_reg(int rd, word_t v);
    if (rd != 0) begin
      mdl[rd] = v;
    end
  endfunction

  function automatic void emit_r(op_kind_e k, int rd, int rs1, int rs2);
    int f7;
    f7 = (k == k_sub || k == k_sra) ? 32 : 0;
    prog.push_back(enc_r(f7, kind_f3(k), rd, rs1, rs2));
    set_reg(rd, ref_op(k, mdl[rs1], mdl[rs2]));
  endfunction

  function automatic void emit_i(op_kind_e k, int rd, int rs1, int imm);
    int          field;
    logic [11:0] imm12;
    if (k == k_sll || k == k_srl || k == k_sra) begin
      field = (imm & 31) | ((k == k_sra) ? 1024 : 0);
    end else begin
      field = imm;
    end
    imm12 = 12'(field);
    prog.push_back(enc_i(op_itype, kind_f3(k), rd, rs1, field));
    set_reg(rd, ref_op(k, mdl[rs1], {{20{imm12[11]}}, imm12}));
  endfunction

  function automatic void emit_lui(int rd, int imm20);
    prog.push_back({20'(imm20), 5'(rd), op_lui});
    set_reg(rd, {20'(imm20), 12'b0});
  endfunction

  function automatic void emit_lw(int rd, int off);
    prog.push_back(enc_i(op_load, 2, rd, 0, off));
    set_reg(rd, fill_word(off / 4));
  endfunction

  function automatic void emit_nops(int n);
    for (int i = 0; i < n; i++) begin
      prog.push_back(nop_instr);
    end
  endfunction

  // Stores go to consecutive words from 0x100
  function automatic void emit_store_if(int rs2, logic expect_it);
    prog.push_back(enc_s(rs2, 0, store_ptr));
    if (expect_it) begin
      exp_addr.push_back(word_t'(store_ptr));
      exp_data.push_back(mdl[rs2]);
    end
    store_ptr += 4;
  endfunction

  function automatic void emit_store(int rs2);
    emit_store_if(rs2, 1'b1);
  endfunction

  // Two stores in the shadow appear only when not taken
  function automatic void emit_branch(int f3, int rs1, int rs2);
    logic taken;
    taken = ref_cond(f3, mdl[rs1], mdl[rs2]);
    prog.push_back(enc_b(f3, rs1, rs2, 12));
    emit_store_if(rs1, !taken);
    emit_store_if(rs2, !taken);
  endfunction

  function automatic void start_test();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    store_ptr = 32'h100;
    for (int i = 0; i < 32; i++) begin
      mdl[i] = '0;
    end
  endfunction

  task automatic run_program(string name);
    int errs;
    int n;
    prog.push_back(enc_s(0, 0, int'(halt_addr)));
    u_clk.hold_reset();
    for (int i = 0; i < 256; i++) begin
      imem[i] <= (i < prog.size()) ? prog[i] : nop_instr;
      dmem[i] <= fill_word(i);
    end
    got_addr.delete();
    got_data.delete();
    halted      <= 1'b0;
    test_name   = name;
    cycle_limit = 4 * prog.size() + 40;
    cycle_count = 0;
    u_clk.release_reset();
    running <= 1'b1;
    wait (halted);
    running <= 1'b0;
    @(posedge clk);

    errs = error_count;
    assert (got_addr.size() == exp_addr.size()) else begin
      $display("FAIL %s store count expected %0d actual %0d",
               name, exp_addr.size(), got_addr.size());
      error_count++;
    end
    n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      assert (got_addr[i] == exp_addr[i]) else begin
        $display("FAIL %s store %0d address expected %h actual %h",
                 name, i, exp_addr[i], got_addr[i]);
        error_count++;
      end
      assert (got_data[i] == exp_data[i]) else begin
        $display("FAIL %s store %0d data expected %h actual %h",
                 name, i, exp_data[i], got_data[i]);
        error_count++;
      end
    end
    test_count++;
    if (error_count != errs) begin
      failed_tests++;
      $display("%s: failed with %0d errors", name, error_count - errs);
    end else begin
      $display("%s: ok, %0d stores", name, n);
    end
  endtask

  task automatic test_alu_ops();
    start_test();
    emit_lui(1, int'(lcg_next() >> 12));
    emit_i(k_add, 1, 1, int'(lcg_next() & 32'h7ff));
    emit_lui(2, 32'hfedcb);
    emit_i(k_add, 2, 2, int'(lcg_next() & 32'h3ff));
    emit_nops(3);
    for (int k = 0; k < 10; k++) begin
      emit_r(op_kind_e'(k), 10, 1, 2);
      emit_nops(3);
      emit_store(10);
    end
    for (int k = 0; k < 10; k++) begin
      if (op_kind_e'(k) != k_sub) begin
        emit_i(op_kind_e'(k), 11, 2, (k >= int'(k_sll)) ? 13 : -37);
        emit_nops(3);
        emit_store(11);
      end
    end
    emit_lui(12, 12345);
    emit_nops(3);
    emit_store(12);
    run_program("alu_ops");
  endtask

  task automatic test_forwarding();
    start_test();
    emit_i(k_add, 1, 0, 5);
    emit_r(k_add, 2, 1, 1);
    emit_i(k_add, 3, 0, -9);
    emit_nops(1);
    emit_r(k_sub, 4, 3, 2);
    emit_r(k_xor, 5, 2, 4);
    emit_store(5);
    emit_i(k_add, 6, 5, 3);
    emit_nops(1);
    emit_store(6);
    emit_i(k_or, 7, 6, 64);
    emit_nops(2);
    emit_store(7);
    emit_store(2);
    emit_store(4);
    emit_i(k_add, 8, 0, 100);
    emit_i(k_add, 9, 0, -3);
    emit_r(k_add, 10, 8, 9);
    emit_store(10);
    // Newest writer of x11 must win
    emit_i(k_add, 11, 0, 1);
    emit_i(k_add, 11, 0, 2);
    emit_r(k_add, 12, 11, 11);
    emit_store(12);
    run_program("forwarding");
  endtask

  task automatic test_load_use();
    start_test();
    emit_i(k_add, 3, 0, 17);
    emit_lw(1, 32'h40);
    emit_r(k_add, 2, 1, 3);
    emit_store(2);
    emit_lw(4, 32'h44);
    emit_store(4);
    emit_lw(5, 32'h48);
    emit_r(k_sub, 6, 3, 5);
    emit_store(6);
    run_program("load_use");
  endtask

  task automatic test_branches();
    int f3s [6];
    int pc;
    f3s = '{0, 1, 4, 5, 6, 7};
    start_test();
    emit_i(k_add, 1, 0, -4);
    emit_i(k_add, 2, 0, 9);
    emit_i(k_add, 3, 0, -4);
    foreach (f3s[i]) begin
      emit_branch(f3s[i], 1, 3);
      emit_branch(f3s[i], 1, 2);
      emit_branch(f3s[i], 2, 1);
    end
    pc = 4 * prog.size();
    prog.push_back(enc_j(5, 12));
    set_reg(5, word_t'(pc + 4));
    emit_store_if(1, 1'b0);
    emit_store_if(2, 1'b0);
    emit_store(5);
    // Odd jalr base so bit 0 of the target must be cleared
    pc = 4 * (prog.size() + 1);
    emit_i(k_add, 6, 0, pc + 13);
    prog.push_back(enc_i(op_jalr, 0, 7, 6, 0));
    set_reg(7, word_t'(pc + 4));
    emit_store_if(1, 1'b0);
    emit_store_if(2, 1'b0);
    emit_store(7);
    run_program("branches");
  endtask

  task automatic test_zero_reg();
    start_test();
    emit_i(k_add, 1, 0, 77);
    emit_i(k_add, 0, 0, 123);
    emit_store(0);
    emit_r(k_add, 0, 1, 1);
    emit_store(0);
    emit_r(k_add, 2, 0, 1);
    emit_store(2);
    emit_lw(0, 32'h50);
    emit_store(0);
    run_program("zero_reg");
  endtask

  task automatic test_random_alu();
    op_kind_e k;
    int       rd;
    int       rs1;
    int       rs2;
    int       imm;
    start_test();
    for (int r = 1; r < 8; r++) begin
      emit_i(k_add, r, 0, int'(lcg_next() >> 21) - 1024);
    end
    for (int i = 0; i < 40; i++) begin
      k   = op_kind_e'(int'((lcg_next() >> 16) % 10));
      rd  = 1 + int'((lcg_next() >> 16) % 7);
      rs1 = 1 + int'((lcg_next() >> 16) % 7);
      rs2 = 1 + int'((lcg_next() >> 16) % 7);
      if (((lcg_next() >> 16) & 32'd1) != 0 && k != k_sub) begin
        if (k == k_sll || k == k_srl || k == k_sra) begin
          imm = int'((lcg_next() >> 16) % 32);
        end else begin
          imm = int'(lcg_next() >> 20) - 2048;
        end
        emit_i(k, rd, rs1, imm);
      end else begin
        emit_r(k, rd, rs1, rs2);
      end
    end
    for (int r = 1; r < 8; r++) begin
      emit_store(r);
    end
    run_program("random_alu");
  endtask

  task automatic finish_run();
    $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
             test_count, failed_tests, error_count);
    if (failed_tests == 0 && error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      imem[i] <= nop_instr;
      dmem[i] <= fill_word(i);
    end
    lcg_state    = 32'hc630_cbaa;
    halted       <= 1'b0;
    running      <= 1'b0;
    cycle_count  = 0;
    cycle_limit  = 0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    test_alu_ops();
    test_forwarding();
    test_load_use();
    test_branches();
    test_zero_reg();
    test_random_alu();
    finish_run();
  end

endmodule
